// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --timescale 1ns/1ps
TOP   = cache_tb
FLIST = src.f
PASS  = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

// ==== cache_clock_gen.sv ====
/* clock and reset source for the cache testbench
   40 ns clock, reset held high for the first 4 rising edges */

`timescale 1ns/1ps

module cache_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // 40 ns period
  end

  // release lands just after an edge, like the other driven inputs
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// ==== cache_ctrl.sv ====
/* blocking cache controller
   FSM for tag check, eviction, refill, data access and the processor response */

`timescale 1ns/1ps

module cache_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 proc_req,
  input  cache_pkg::req_type_t req_type,
  input  logic                 hit,
  input  cache_pkg::way_t      hit_way,
  input  cache_pkg::way_t      victim_way,
  input  logic                 victim_dirty,
  input  logic                 mem_ack,
  output logic                 capture,
  output logic                 tag_we,
  output logic                 valid_set,
  output logic                 dirty_we,
  output logic                 dirty_val,
  output logic                 lru_we,
  output cache_pkg::way_t      access_way,
  output cache_pkg::way_t      data_way,
  output logic                 data_we,
  output logic                 use_mem,
  output logic                 mem_req,
  output logic                 mem_we,
  output logic                 mem_sel_victim,
  output logic                 resp_load,
  output logic                 resp_hit,
  output logic                 ack_set,
  output logic                 ack_clear
);

  typedef enum logic [3:0] {
    s_idle, s_tag_check, s_data_access, s_evict_req, s_evict_release,
    s_refill_req, s_refill_release, s_refill_update, s_respond, s_release
  } state_t;

  state_t state;
  state_t state_next;
  logic   is_init;
  logic   is_write;
  logic   hit_q;          // tag-check hit kept for the response

  assign is_init  = (req_type == cache_pkg::REQ_INIT);
  assign is_write = (req_type == cache_pkg::REQ_WRITE);

  // --------------------
  // state register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
      hit_q <= 1'b0;
    end else begin
      state <= state_next;
      if (state == s_tag_check) begin
        hit_q <= hit && !is_init;   // init and misses report 0
      end
    end
  end

  assign resp_hit = hit_q;

  // --------------------
  // transitions
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      s_idle:           if (proc_req) state_next = s_tag_check;
      s_tag_check: begin
        if (is_init || hit) state_next = s_data_access;
        else if (victim_dirty) state_next = s_evict_req;
        else state_next = s_refill_req;
      end
      s_evict_req:      if (mem_ack) state_next = s_evict_release;
      s_evict_release:  if (!mem_ack) state_next = s_refill_req;
      s_refill_req:     if (mem_ack) state_next = s_refill_release;
      s_refill_release: if (!mem_ack) state_next = s_refill_update;
      s_refill_update:  state_next = s_data_access;   // line now hits
      s_data_access:    state_next = s_respond;
      s_respond:        if (!proc_req) state_next = s_release;   // hold while req is high
      s_release:        state_next = s_idle;
      default:          state_next = s_idle;
    endcase
  end

  // --------------------
  // control outputs
  // --------------------

  always_comb begin
    capture        = 1'b0;
    tag_we         = 1'b0;
    valid_set      = 1'b0;
    dirty_we       = 1'b0;
    dirty_val      = 1'b0;
    lru_we         = 1'b0;
    access_way     = hit_way;
    data_way       = hit_way;
    data_we        = 1'b0;
    use_mem        = 1'b0;
    mem_req        = 1'b0;
    mem_we         = 1'b0;
    mem_sel_victim = 1'b0;
    resp_load      = 1'b0;
    ack_set        = 1'b0;
    ack_clear      = 1'b0;
    case (state)
      s_idle:       capture = proc_req;
      s_evict_req: begin
        mem_req        = 1'b1;
        mem_we         = 1'b1;
        mem_sel_victim = 1'b1;        // victim tag forms the address
        data_way       = victim_way;  // victim word drives mem_wdata
      end
      s_refill_req: begin
        mem_req  = 1'b1;
        data_way = victim_way;
        data_we  = mem_ack;           // mem_rdata is only valid while ack is high
        use_mem  = 1'b1;
      end
      s_refill_update: begin
        access_way = victim_way;
        tag_we     = 1'b1;
        valid_set  = 1'b1;
        dirty_we   = 1'b1;            // refilled line starts clean
      end
      s_data_access: begin
        lru_we = 1'b1;
        if (is_init) begin
          access_way = victim_way;    // init installs over the victim
          data_way   = victim_way;
          data_we    = 1'b1;
          tag_we     = 1'b1;
          valid_set  = 1'b1;
          dirty_we   = 1'b1;
        end else if (is_write) begin
          data_we   = 1'b1;
          dirty_we  = 1'b1;
          dirty_val = 1'b1;
        end
      end
      s_respond: begin
        resp_load = 1'b1;             // stored word after any write
        ack_set   = 1'b1;
      end
      s_release:    ack_clear = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== cache_data_array.sv ====
/* data array
   two ways of word storage, combinational read, write of request or memory word */

`timescale 1ns/1ps

module cache_data_array (
  input  logic              clk,
  input  cache_pkg::index_t req_index,
  input  cache_pkg::way_t   way,         // selects both read and write way
  input  logic              we,
  input  logic              use_mem,     // 1 on refill
  input  cache_pkg::data_t  req_wdata,
  input  cache_pkg::data_t  mem_rdata,
  output cache_pkg::data_t  rdata
);

  cache_pkg::data_t words [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
  cache_pkg::data_t wdata;

  // refill takes the memory word, write and init take the request word
  assign wdata = use_mem ? mem_rdata : req_wdata;

  always_ff @(posedge clk) begin
    if (we) begin
      words[way][req_index] <= wdata;
    end
  end

  // --------------------
  // read port
  // --------------------

  // feeds both the response register and mem_wdata on eviction
  assign rdata = words[way][req_index];

endmodule

// ==== cache_pkg.sv ====
/* cache package
   geometry, request codes and vector types for the two-way blocking cache */

package cache_pkg;

  // --------------------
  // geometry
  // --------------------

  localparam int ADDR_BITS = 32;          // byte address width
  localparam int DATA_BITS = 32;          // one word per line
  localparam int NUM_SETS  = 8;
  localparam int NUM_WAYS  = 2;

  localparam int INDEX_LSB = 2;           // word aligned, bits [1:0] unused
  localparam int TAG_LSB   = 5;           // tag sits above the 3 index bits

  localparam int INDEX_BITS = TAG_LSB - INDEX_LSB;
  localparam int TAG_BITS   = ADDR_BITS - TAG_LSB;

  // --------------------
  // vector types
  // --------------------

  typedef logic [ADDR_BITS-1:0]  addr_t;
  typedef logic [DATA_BITS-1:0]  data_t;
  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [1:0]            req_type_t;
  typedef logic                  way_t;   // 0 or 1

  // --------------------
  // request codes
  // --------------------

  localparam req_type_t REQ_READ  = 2'd0;
  localparam req_type_t REQ_WRITE = 2'd1;
  localparam req_type_t REQ_INIT  = 2'd2;  // install word, no memory traffic

endpackage

// ==== cache_req_decode.sv ====
/* request decode
   holds the processor request for the whole transaction and splits the address */

`timescale 1ns/1ps

module cache_req_decode (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 capture,     // strobe from the FSM in idle
  input  cache_pkg::req_type_t proc_type,
  input  cache_pkg::addr_t     proc_addr,
  input  cache_pkg::data_t     proc_wdata,
  output cache_pkg::req_type_t req_type,
  output cache_pkg::tag_t      req_tag,
  output cache_pkg::index_t    req_index,
  output cache_pkg::data_t     req_wdata
);

  // request type steers the FSM, so it comes out of reset as a read
  always_ff @(posedge clk) begin
    if (reset) begin
      req_type <= cache_pkg::REQ_READ;
    end else if (capture) begin
      req_type <= proc_type;
    end
  end

  // address fields and write word
  always_ff @(posedge clk) begin
    if (capture) begin
      req_tag   <= proc_addr[cache_pkg::ADDR_BITS-1:cache_pkg::TAG_LSB];
      req_index <= proc_addr[cache_pkg::TAG_LSB-1:cache_pkg::INDEX_LSB];
      req_wdata <= proc_wdata;
    end
  end

  // proc_addr[1:0] is the byte offset and is dropped here
  // the stored fields stay put after the processor lowers req,
  // until the next capture in idle

endmodule

// ==== cache_resp_result.sv ====
/* response result
   response word and hit registers, plus the processor-side ack flop */

`timescale 1ns/1ps

module cache_resp_result (
  input  logic             clk,
  input  logic             reset,
  input  logic             resp_load,
  input  logic             resp_hit,
  input  cache_pkg::data_t rdata,
  input  logic             ack_set,     // respond state
  input  logic             ack_clear,   // release state
  output cache_pkg::data_t proc_rdata,
  output logic             proc_hit,
  output logic             proc_ack
);

  // --------------------
  // response registers
  // --------------------

  always_ff @(posedge clk) begin
    if (resp_load) begin
      proc_rdata <= rdata;   // read word, or the word just stored
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      proc_hit <= 1'b0;
    end else if (resp_load) begin
      proc_hit <= resp_hit;
    end
  end

  // --------------------
  // four-phase ack
  // --------------------

  // rises with the response load, falls one cycle after req drops
  always_ff @(posedge clk) begin
    if (reset) begin
      proc_ack <= 1'b0;
    end else if (ack_set) begin
      proc_ack <= 1'b1;
    end else if (ack_clear) begin
      proc_ack <= 1'b0;
    end
  end

endmodule

// ==== cache_stimulus.txt ====
# op addr wdata exp_rdata exp_hit evict evict_addr evict_data hold, all hex
# op 0 read, 1 write, 2 init; hold is extra cycles of req after ack
0 00000100 00000000 a5a50100 0 0 00000000 00000000 0
0 00000100 00000000 a5a50100 1 0 00000000 00000000 0
1 00000104 11112222 11112222 0 0 00000000 00000000 0
0 00000104 00000000 11112222 1 0 00000000 00000000 0
1 00000100 33334444 33334444 1 0 00000000 00000000 0
0 00000100 00000000 33334444 1 0 00000000 00000000 0
2 00000108 55556666 55556666 0 0 00000000 00000000 0
0 00000108 00000000 55556666 1 0 00000000 00000000 0
0 00000200 00000000 a5a50200 0 0 00000000 00000000 0
0 00000100 00000000 33334444 1 0 00000000 00000000 0
0 00000200 00000000 a5a50200 1 0 00000000 00000000 0
0 00000100 00000000 33334444 1 0 00000000 00000000 0
0 00000300 00000000 a5a50300 0 0 00000000 00000000 0
0 00000400 00000000 a5a50400 0 1 00000100 33334444 0
0 00000100 00000000 33334444 0 0 00000000 00000000 0
1 0000010c 77778888 77778888 0 0 00000000 00000000 0
1 0000020c 9999aaaa 9999aaaa 0 0 00000000 00000000 0
0 0000030c 00000000 a5a5030c 0 1 0000010c 77778888 0
0 0000020c 00000000 9999aaaa 1 0 00000000 00000000 3
0 0000010c 00000000 77778888 0 0 00000000 00000000 0
0 0000040c 00000000 a5a5040c 0 1 0000020c 9999aaaa 0
2 00000114 bbbbcccc bbbbcccc 0 0 00000000 00000000 2
0 00000114 00000000 bbbbcccc 1 0 00000000 00000000 0

// ==== cache_tag_check.sv ====
/* tag check
   per-way tags with valid and dirty bits, one replacement bit per set,
   combinational hit and victim selection for the stored index */

`timescale 1ns/1ps

module cache_tag_check (
  input  logic               clk,
  input  logic               reset,
  input  cache_pkg::tag_t    req_tag,
  input  cache_pkg::index_t  req_index,
  input  logic               tag_we,       // write req_tag into access_way
  input  logic               valid_set,    // mark access_way valid
  input  logic               dirty_we,
  input  logic               dirty_val,
  input  logic               lru_we,       // access_way was just used
  input  cache_pkg::way_t    access_way,
  output logic               hit,
  output cache_pkg::way_t    hit_way,
  output cache_pkg::way_t    victim_way,
  output logic               victim_dirty,
  output cache_pkg::tag_t    victim_tag
);

  // --------------------
  // storage
  // --------------------

  cache_pkg::tag_t tags [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] valid;
  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::NUM_SETS-1:0] dirty;
  logic [cache_pkg::NUM_SETS-1:0]                          lru;   // names the victim way

  logic [cache_pkg::NUM_WAYS-1:0] way_match;

  // tag arrays
  always_ff @(posedge clk) begin
    if (tag_we) begin
      tags[access_way][req_index] <= req_tag;
    end
  end

  // state bits, all lines invalid and way 0 as victim after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (valid_set) begin
        valid[access_way][req_index] <= 1'b1;
      end
      if (dirty_we) begin
        dirty[access_way][req_index] <= dirty_val;
      end
      if (lru_we) begin
        lru[req_index] <= ~access_way;   // the other way goes next
      end
    end
  end

  // --------------------
  // hit and victim
  // --------------------

  always_comb begin
    for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
      way_match[w] = valid[w][req_index] && (tags[w][req_index] == req_tag);
    end
  end

  assign hit     = |way_match;
  assign hit_way = ~way_match[0] & way_match[1];   // way 0 wins, 0 on a miss

  assign victim_way   = lru[req_index];
  assign victim_dirty = valid[victim_way][req_index] && dirty[victim_way][req_index];
  assign victim_tag   = tags[victim_way][req_index];   // eviction address

endmodule

// ==== cache_tb.sv ====
/* cache testbench
   reads requests from the stimulus file, drives the processor handshake,
   models memory with an LCG ack delay and checks responses and evictions */

`timescale 1ns/1ps

module cache_tb;

  localparam int          MAX_REQ      = 64;
  localparam int          CLK_PERIOD   = 40;
  localparam int          WORST_CYCLES = 40;   // dirty miss with slow memory plus hold
  localparam logic [31:0] PRELOAD_XOR  = 32'ha5a50000;

  logic                 clk;
  logic                 reset;
  logic                 proc_req;
  cache_pkg::req_type_t proc_type;
  cache_pkg::addr_t     proc_addr;
  cache_pkg::data_t     proc_wdata;
  cache_pkg::data_t     proc_rdata;
  logic                 proc_hit;
  logic                 proc_ack;
  logic                 mem_req;
  logic                 mem_we;
  cache_pkg::addr_t     mem_addr;
  cache_pkg::data_t     mem_wdata;
  cache_pkg::data_t     mem_rdata;
  logic                 mem_ack;

  // stimulus columns op addr wdata rdata hit evict evict_addr evict_data hold
  logic [31:0] stim [MAX_REQ][9];
  int          n_req = 0;
  int          errors = 0;
  bit          loaded = 1'b0;
  logic [31:0] lcg_state = 32'd705;
  logic [31:0] mem_words [logic [31:0]];   // written words, the preload rule covers the rest
  int          rd_count = 0;
  int          wr_count = 0;
  bit          wr_after_rd = 1'b0;            // eviction must come before the refill read
  logic [31:0] wr_addr, wr_data;

  cache_clock_gen i_clock_gen (.clk, .reset);

  cache_top i_cache_top (
    .clk, .reset, .proc_req, .proc_type, .proc_addr, .proc_wdata, .proc_rdata,
    .proc_hit, .proc_ack, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack
  );

  function automatic int lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);
  endfunction

  function automatic logic [31:0] memory_word(input logic [31:0] addr);
    if (mem_words.exists(addr)) return mem_words[addr];
    return addr ^ PRELOAD_XOR;
  endfunction

  task automatic report_mismatch(input int i, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED req %0d %s: got %h expected %h", i, name, got, exp);
  endtask

  // --------------------
  // stimulus file
  // --------------------

  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    fd = $fopen("cache_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("stimulus file cache_stimulus.txt could not be opened");
      return;
    end
    while (!$feof(fd) && n_req < MAX_REQ) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line.getc(0) == "#") continue;   // blank or comment
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", stim[n_req][0], stim[n_req][1],
                  stim[n_req][2], stim[n_req][3], stim[n_req][4], stim[n_req][5],
                  stim[n_req][6], stim[n_req][7], stim[n_req][8]);
      if (n == 9) begin
        n_req++;
      end else begin
        errors++;
        $display("stimulus line could not be parsed: %s", line);
      end
    end
    $fclose(fd);
    if (n_req == 0) begin
      errors++;
      $display("stimulus file holds no requests");
    end
  endtask

  // --------------------
  // processor driver
  // --------------------

  task automatic run_request(input int i);
    logic [1:0]  op;
    logic [31:0] exp_rdata;
    logic        exp_hit;
    int          exp_reads;
    int          cycles;
    op        = stim[i][0][1:0];
    exp_rdata = stim[i][3];
    exp_hit   = stim[i][4][0];
    exp_reads = (op != cache_pkg::REQ_INIT && !exp_hit) ? 1 : 0;   // one refill per miss
    @(posedge clk);
    #1;
    proc_type  = op;
    proc_addr  = stim[i][1];
    proc_wdata = stim[i][2];
    proc_req   = 1'b1;
    cycles     = 0;
    while (!proc_ack) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (proc_rdata !== exp_rdata) report_mismatch(i, "proc_rdata", proc_rdata, exp_rdata);
    if (proc_hit !== exp_hit) report_mismatch(i, "proc_hit", 32'(proc_hit), 32'(exp_hit));
    // hit and init take capture, tag check, data access and response load
    if ((exp_hit || op == cache_pkg::REQ_INIT) && cycles != 4)
      report_mismatch(i, "ack latency", cycles, 4);
    repeat (stim[i][8]) begin   // response stays put while the processor keeps req high
      @(posedge clk);
      #1;
      if (proc_ack !== 1'b1) report_mismatch(i, "proc_ack", 32'(proc_ack), 1);
      if (proc_rdata !== exp_rdata) report_mismatch(i, "proc_rdata", proc_rdata, exp_rdata);
      if (proc_hit !== exp_hit) report_mismatch(i, "proc_hit", 32'(proc_hit), 32'(exp_hit));
    end
    proc_req = 1'b0;
    while (proc_ack) begin
      @(posedge clk);
      #1;
    end
    // memory traffic since the end of the previous request
    if (rd_count != exp_reads) report_mismatch(i, "memory reads", rd_count, exp_reads);
    if (wr_count != stim[i][5]) report_mismatch(i, "memory writes", wr_count, stim[i][5]);
    if (stim[i][5] != 0 && wr_count == 1) begin
      if (wr_addr !== stim[i][6]) report_mismatch(i, "mem_addr", wr_addr, stim[i][6]);
      if (wr_data !== stim[i][7]) report_mismatch(i, "mem_wdata", wr_data, stim[i][7]);
      if (wr_after_rd) begin
        errors++;
        $display("req %0d: the eviction write came after the refill read", i);
      end
    end
    rd_count    = 0;
    wr_count    = 0;
    wr_after_rd = 1'b0;
  endtask

  // --------------------
  // memory model
  // --------------------

  initial begin : memory_model
    int delay;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      #1;
      if (mem_req && !mem_ack) begin
        delay = lcg_next() % 4;   // 0 to 3 extra cycles
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        if (mem_we) begin
          mem_words[mem_addr] = mem_wdata;
          wr_addr     = mem_addr;
          wr_data     = mem_wdata;
          wr_after_rd = (rd_count != 0);
          wr_count++;
        end else begin
          mem_rdata = memory_word(mem_addr);
          rd_count++;
        end
        mem_ack = 1'b1;
        while (mem_req) begin
          @(posedge clk);
          #1;
        end
        mem_ack = 1'b0;
      end
    end
  end

  // --------------------
  // main sequence and watchdog
  // --------------------

  initial begin
    proc_req   = 1'b0;
    proc_type  = cache_pkg::REQ_READ;
    proc_addr  = '0;
    proc_wdata = '0;
    load_stimulus();
    loaded = 1'b1;
    wait (reset == 1'b0);
    for (int i = 0; i < n_req; i++) begin
      run_request(i);
    end
    $display("requests %0d, errors %0d", n_req, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #((n_req * WORST_CYCLES + 10) * CLK_PERIOD);
    $display("timeout: the requests did not finish in the worst-case time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== cache_top.sv ====
/* cache top
   two-way blocking cache with four-phase processor and memory handshakes */

`timescale 1ns/1ps

module cache_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 proc_req,
  input  cache_pkg::req_type_t proc_type,
  input  cache_pkg::addr_t     proc_addr,
  input  cache_pkg::data_t     proc_wdata,
  output cache_pkg::data_t     proc_rdata,
  output logic                 proc_hit,
  output logic                 proc_ack,
  output logic                 mem_req,
  output logic                 mem_we,
  output cache_pkg::addr_t     mem_addr,
  output cache_pkg::data_t     mem_wdata,
  input  cache_pkg::data_t     mem_rdata,
  input  logic                 mem_ack
);

  cache_pkg::req_type_t req_type;
  cache_pkg::tag_t      req_tag;
  cache_pkg::index_t    req_index;
  cache_pkg::data_t     req_wdata;
  cache_pkg::tag_t      victim_tag;
  cache_pkg::tag_t      mem_tag;
  cache_pkg::data_t     rdata;
  cache_pkg::way_t      hit_way, victim_way, access_way, data_way;
  logic capture, hit, victim_dirty;
  logic tag_we, valid_set, dirty_we, dirty_val, lru_we;
  logic data_we, use_mem, mem_sel_victim;
  logic resp_load, resp_hit, ack_set, ack_clear;

  // --------------------
  // decode
  // --------------------

  cache_req_decode i_req_decode (
    .clk, .reset, .capture, .proc_type, .proc_addr, .proc_wdata,
    .req_type, .req_tag, .req_index, .req_wdata
  );

  // --------------------
  // execute
  // --------------------

  cache_tag_check i_tag_check (
    .clk, .reset, .req_tag, .req_index, .tag_we, .valid_set, .dirty_we,
    .dirty_val, .lru_we, .access_way, .hit, .hit_way, .victim_way,
    .victim_dirty, .victim_tag
  );

  cache_ctrl i_ctrl (
    .clk, .reset, .proc_req, .req_type, .hit, .hit_way, .victim_way,
    .victim_dirty, .mem_ack, .capture, .tag_we, .valid_set, .dirty_we,
    .dirty_val, .lru_we, .access_way, .data_way, .data_we, .use_mem,
    .mem_req, .mem_we, .mem_sel_victim, .resp_load, .resp_hit, .ack_set, .ack_clear
  );

  cache_data_array i_data_array (
    .clk, .req_index, .way(data_way), .we(data_we), .use_mem,
    .req_wdata, .mem_rdata, .rdata
  );

  // memory address, eviction uses the stored tag of the victim line
  assign mem_tag   = mem_sel_victim ? victim_tag : req_tag;
  assign mem_addr  = {mem_tag, req_index, {cache_pkg::INDEX_LSB{1'b0}}};
  assign mem_wdata = rdata;

  // --------------------
  // result
  // --------------------

  cache_resp_result i_resp_result (
    .clk, .reset, .resp_load, .resp_hit, .rdata, .ack_set, .ack_clear,
    .proc_rdata, .proc_hit, .proc_ack
  );

endmodule

// ==== src.f ====
cache_pkg.sv
cache_req_decode.sv
cache_tag_check.sv
cache_ctrl.sv
cache_data_array.sv
cache_resp_result.sv
cache_top.sv
cache_clock_gen.sv
cache_tb.sv
